/* sources.f */
+incdir+tests
common/snappy_pkg.sv
verilog/lead_zero_count.sv
verilog/cmd_fifo.sv
parser/token_decode.sv
parser/token_walker.sv
parser/parser_top.sv
tests/tb_parser.sv

/* run.sh */
#!/bin/sh
# build the parser testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any $fatal

verilator --binary --timing -j 0 \
	--top-module tb_parser \
	-f sources.f \
	-o tb_parser \
	&& ./obj_dir/tb_parser \
	|| { echo "parser simulation failed"; exit 1; }

/* tests/tb_stream_model.svh */
// stream model: random tokens, slicing with masks and garbage, expected command queues
slice_t    slice_q[$];
lit_cmd_t  exp_lit_q[$];
copy_cmd_t exp_copy_q[$];
slice_t    cur;		// slice being filled
int        used;	// bytes placed in cur
int        cap;		// usable bytes, 16 minus picked garbage
bit        open_q;
addr_t     out_addr;	// output address of the next stream byte

task automatic open_slice(input bit lit_first);
	cur           = '0;
	cur.addr      = out_addr;	// token or continuation content at byte 0
	cur.lit_first = lit_first;
	used          = 0;
	cap           = SLICE_BYTES;
	if (rand_bits(2) == 0) cap = SLICE_BYTES - int'(rand_bits(3)) % 6;
	open_q = 1'b1;
endtask

task automatic close_slice();
	for (int i = used; i < SLICE_BYTES; i++) begin
		cur.data[127 - 8 * i -: 8] = byte_t'(rand_bits(8));	// junk in the tail
	end
	cur.garbage = 3'(SLICE_BYTES - used);
	slice_q.push_back(cur);
	open_q = 1'b0;
endtask

task automatic put_byte(input byte_t b, input bit start);
	cur.data[127 - 8 * used -: 8] = b;
	if (start) cur.tok_pos[15 - used] = 1'b1;
	used++;
endtask

// a header never crosses a slice end
task automatic make_room(input int n);
	if (!open_q) begin
		open_slice(1'b0);
	end else if (cap - used < n) begin
		close_slice();
		open_slice(1'b0);
	end
endtask

task automatic add_literal(input int len, input int hdr);
	logic [15:0] lm1;
	lit_cmd_t    c;
	int          n;
	lm1 = 16'(len - 1);
	make_room(hdr);
	if (hdr == 1) begin
		put_byte({lm1[5:0], TAG_LIT}, 1'b1);
	end else if (hdr == 2) begin
		put_byte({LIT_LEN_1B, TAG_LIT}, 1'b1);
		put_byte(lm1[7:0], 1'b0);
	end else begin
		put_byte({LIT_LEN_2B, TAG_LIT}, 1'b1);
		put_byte(lm1[7:0], 1'b0);	// little endian length
		put_byte(lm1[15:8], 1'b0);
	end
	while (len > 0) begin
		if (used == cap) begin
			close_slice();
			open_slice(1'b1);	// content goes on in the next slice
		end
		n        = (len < cap - used) ? len : cap - used;
		c        = '0;
		c.addr   = out_addr;
		c.cnt_m1 = lit_cnt_t'(n - 1);
		for (int k = 0; k < n; k++) begin
			c.data[127 - 8 * k -: 8] = byte_t'(rand_bits(8));
			put_byte(c.data[127 - 8 * k -: 8], 1'b0);
		end
		exp_lit_q.push_back(c);
		out_addr += addr_t'(n);
		len -= n;
	end
endtask

task automatic add_copy(input bit three);
	offset_t   off;
	copy_len_t len;
	logic [5:0] f;
	if (three) begin
		f   = 6'(rand_bits(6));
		len = copy_len_t'(f) + 7'd1;
		off = offset_t'(rand_bits(16));
		make_room(3);
		put_byte({f, TAG_COPY3}, 1'b1);
		put_byte(off[7:0], 1'b0);
		put_byte(off[15:8], 1'b0);
	end else begin
		f   = 6'(rand_bits(3));
		len = copy_len_t'(f) + 7'd4;
		off = offset_t'(rand_bits(11));
		make_room(2);
		put_byte({off[10:8], f[2:0], TAG_COPY2}, 1'b1);
		put_byte(off[7:0], 1'b0);
	end
	exp_copy_q.push_back('{addr: out_addr, offset: off, len: len});
	out_addr += addr_t'(len);
endtask

task automatic build_stream(input int ntok);
	slice_q.delete();
	exp_lit_q.delete();
	exp_copy_q.delete();
	open_q = 1'b0;
	for (int t = 0; t < ntok; t++) begin
		case (rand_bits(3))
			0, 1:    add_literal(int'(rand_bits(3)) + 1, 1);
			2:       add_literal(int'(rand_bits(6)) % 60 + 1, 1);
			3:       add_literal(int'(rand_bits(8)) + 1, 2);
			4:       add_literal(int'(rand_bits(9)) + 1, 3);
			5, 6:    add_copy(1'b0);
			default: add_copy(1'b1);
		endcase
	end
	// pad the last slice so its garbage fits in three bits
	if (open_q) begin
		if (cap - used >= 2) add_literal(cap - used - 1, 1);
		close_slice();
	end
endtask

/* tests/tb_parser.sv */
// parser testbench with clock, reset, LFSR, slice driver, command readers, compare tasks and run loop
module tb_parser import snappy_pkg::*; ();

	localparam int TIMEOUT = 4000;	// idle cycles allowed per wait

	logic        clk;
	logic        rst_n;
	slice_t      slice_i;
	logic        slice_valid_i;
	logic        ready_o;
	lit_cmd_t    lit_cmd_o;
	logic        lit_valid_o;
	logic        lit_rd_i;
	copy_cmd_t   copy_cmd_o;
	logic        copy_valid_o;
	logic        copy_rd_i;
	logic        all_empty_o;
	logic [31:0] lfsr_q;

	parser_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// period 8
	end

	// fibonacci LFSR over taps 32 22 2 1 stepped once per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v;
	endfunction

	`include "tb_stream_model.svh"

	task automatic check_lit(input string name, input lit_cmd_t exp, input lit_cmd_t act);
		if (act !== exp) begin
			$display("error: %s expected %h actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "literal command mismatch");
		end
	endtask

	task automatic check_copy(input string name, input copy_cmd_t exp, input copy_cmd_t act);
		if (act !== exp) begin
			$display("error: %s expected %h actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "copy command mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error: %s expected %b actual %b", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "status bit mismatch");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout: %s", what);
		$display("Some tests failed");
		$fatal(1, "wait timed out");
	endtask

	// offer slices in order with random gaps on valid if asked
	task automatic send_slices(input string name, input bit gaps);
		int idx;
		int idle;
		idx  = 0;
		idle = 0;
		while (idx < slice_q.size()) begin
			@(posedge clk);
			if (slice_valid_i && ready_o) begin
				idx++;	// taken on this edge
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT) fail_timeout({name, ": slice never accepted"});
			end
			if (idx < slice_q.size() && !(gaps && rand_bits(2) == 0)) begin
				slice_i       <= slice_q[idx];
				slice_valid_i <= 1'b1;
			end else begin
				slice_valid_i <= 1'b0;
			end
		end
	endtask

	// one-cycle read pulses checked on the edge that consumes the entry
	task automatic drain_lit(input string name, input bit stall);
		int got;
		int idle;
		int hold;	// remaining back-pressure cycles
		got  = 0;
		idle = 0;
		hold = 0;
		while (got < exp_lit_q.size()) begin
			@(posedge clk);
			if (lit_rd_i) begin
				check_lit({name, " literal"}, exp_lit_q[got], lit_cmd_o);
				got++;
				idle = 0;
				lit_rd_i <= 1'b0;
			end else begin
				idle++;
				if (idle > TIMEOUT) fail_timeout({name, ": literal command missing"});
				if (hold > 0) begin
					hold--;
				end else if (stall && rand_bits(4) == 0) begin
					hold = int'(rand_bits(7));
				end else if (lit_valid_o) begin
					lit_rd_i <= 1'b1;
				end
			end
		end
	endtask

	task automatic drain_copy(input string name, input bit stall);
		int got;
		int idle;
		int hold;
		got  = 0;
		idle = 0;
		hold = 0;
		while (got < exp_copy_q.size()) begin
			@(posedge clk);
			if (copy_rd_i) begin
				check_copy({name, " copy"}, exp_copy_q[got], copy_cmd_o);
				got++;
				idle = 0;
				copy_rd_i <= 1'b0;
			end else begin
				idle++;
				if (idle > TIMEOUT) fail_timeout({name, ": copy command missing"});
				if (hold > 0) begin
					hold--;
				end else if (stall && rand_bits(4) == 0) begin
					hold = int'(rand_bits(7));
				end else if (copy_valid_o) begin
					copy_rd_i <= 1'b1;
				end
			end
		end
	endtask

	task automatic wait_empty(input string name);
		int t;
		t = 0;
		while (all_empty_o !== 1'b1) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT) fail_timeout({name, ": all_empty_o never went high"});
		end
	endtask

	// leftover commands keep a FIFO busy and all_empty_o low
	task automatic run_phase(input string name, input bit stall, input int ntok);
		build_stream(ntok);
		fork
			send_slices(name, stall);
			drain_lit(name, stall);
			drain_copy(name, stall);
		join
		wait_empty(name);
	endtask

	initial begin
		lfsr_q        = 32'hba19;
		rst_n         = 1'b0;
		slice_i       = '0;
		slice_valid_i = 1'b0;
		lit_rd_i      = 1'b0;
		copy_rd_i     = 1'b0;
		out_addr      = '0;
		repeat (10) @(posedge clk);
		check_bit("reset ready", 1'b0, ready_o);
		check_bit("reset lit_valid", 1'b0, lit_valid_o);
		check_bit("reset copy_valid", 1'b0, copy_valid_o);
		check_bit("reset all_empty", 1'b0, all_empty_o);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);	// one cycle in IDLE, then WAIT_SLICE
		check_bit("ready after reset", 1'b1, ready_o);
		check_bit("lit_valid after reset", 1'b0, lit_valid_o);
		check_bit("copy_valid after reset", 1'b0, copy_valid_o);
		wait_empty("reset");
		run_phase("free_run", 1'b0, 300);	// reads whenever valid
		run_phase("back_pressure", 1'b1, 300);	// long read holds stall the walker
		$display("All tests passed");
		$finish;
	end

endmodule

/* parser/parser_top.sv */
// parser top level: token walker, literal and copy command FIFOs, status outputs
module parser_top import snappy_pkg::*; #(
	parameter int FIFO_DEPTH  = 16,
	parameter int AFULL_LEVEL = FIFO_DEPTH - 3	// room for the pushes in flight behind stop
) (
	input  logic      clk,
	input  logic      rst_n,
	input  slice_t    slice_i,
	input  logic      slice_valid_i,
	output logic      ready_o,
	output lit_cmd_t  lit_cmd_o,
	output logic      lit_valid_o,
	input  logic      lit_rd_i,
	output copy_cmd_t copy_cmd_o,
	output logic      copy_valid_o,
	input  logic      copy_rd_i,
	output logic      all_empty_o
);

	lit_cmd_t  lit_cmd;
	copy_cmd_t copy_cmd;
	logic      lit_push, copy_push;
	logic      lit_afull, copy_afull;
	logic      lit_empty, copy_empty;
	logic      walker_ready;
	logic      all_empty_q;

	token_walker u_walker (
		.clk          (clk),
		.rst_n        (rst_n),
		.slice_i      (slice_i),
		.slice_valid_i(slice_valid_i),
		.ready_o      (walker_ready),
		.lit_afull_i  (lit_afull),
		.copy_afull_i (copy_afull),
		.lit_cmd_o    (lit_cmd),
		.lit_push_o   (lit_push),
		.copy_cmd_o   (copy_cmd),
		.copy_push_o  (copy_push)
	);

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .AFULL_LEVEL(AFULL_LEVEL), .entry_t(lit_cmd_t)) u_lit_fifo (
		.clk(clk), .rst_n(rst_n),
		.din_i(lit_cmd), .push_i(lit_push),
		.afull_o(lit_afull), .empty_o(lit_empty),
		.dout_o(lit_cmd_o), .valid_o(lit_valid_o), .rd_i(lit_rd_i)
	);

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .AFULL_LEVEL(AFULL_LEVEL), .entry_t(copy_cmd_t)) u_copy_fifo (
		.clk(clk), .rst_n(rst_n),
		.din_i(copy_cmd), .push_i(copy_push),
		.afull_o(copy_afull), .empty_o(copy_empty),
		.dout_o(copy_cmd_o), .valid_o(copy_valid_o), .rd_i(copy_rd_i)
	);

	// nothing buffered anywhere and the walker waits for input
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			all_empty_q <= 1'b0;
		end else begin
			all_empty_q <= lit_empty & copy_empty & walker_ready;
		end
	end

	assign ready_o     = walker_ready;
	assign all_empty_o = all_empty_q;

endmodule

/* parser/token_walker.sv */
// token walker FSM with slice buffer, shift by token distance, command emission and stop flag
module token_walker import snappy_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  slice_t    slice_i,
	input  logic      slice_valid_i,
	output logic      ready_o,
	input  logic      lit_afull_i,
	input  logic      copy_afull_i,
	output lit_cmd_t  lit_cmd_o,
	output logic      lit_push_o,
	output copy_cmd_t copy_cmd_o,
	output logic      copy_push_o
);

	walk_state_e state_q;
	slice_data_t data_q;	// head token always in the top bytes
	tok_mask_t   mask_q;	// shifted along with data_q
	addr_t       addr_q;	// output address of the head token
	logic        cont_q;	// head is continuation content
	logic [4:0]  left_q;	// bytes from head to slice end and zero when idle
	logic        stop_q;

	logic        step_en;
	logic        none;		// no further token start in this slice
	logic [3:0]  next_dist;	// bytes to the next token start
	tok_mask_t   tail_mask;
	lit_cmd_t    dec_lit;
	copy_cmd_t   dec_copy;
	logic        dec_lit_emit;
	logic        dec_copy_emit;
	addr_t       addr_step;
	logic [1:0]  hdr_bytes;
	logic [4:0]  lit_cnt;
	slice_data_t lit_keep;

	assign tail_mask = {1'b0, mask_q[14:0]};	// ignore the head's own start bit

	lead_zero_count u_lzc (
		.x_i    (tail_mask),
		.none_o (none),
		.count_o(next_dist)
	);

	token_decode u_decode (
		.head_i     (data_q[127:96]),
		.cont_i     (cont_q),
		.left_i     (left_q),
		.addr_i     (addr_q),
		.next_dist_i(next_dist),
		.none_i     (none),
		.lit_cmd_o  (dec_lit),
		.lit_emit_o (dec_lit_emit),
		.copy_cmd_o (dec_copy),
		.copy_emit_o(dec_copy_emit),
		.addr_step_o(addr_step),
		.hdr_bytes_o(hdr_bytes)
	);

	assign ready_o = (state_q == WAIT_SLICE);
	assign step_en = (state_q == WALK) && !stop_q;

	// literal bytes follow the header and are trimmed to the decoded count
	always_comb begin
		lit_cnt        = {1'b0, dec_lit.cnt_m1} + 5'd1;
		lit_keep       = ~(slice_data_t'('1) >> {lit_cnt, 3'b000});
		lit_cmd_o      = dec_lit;
		lit_cmd_o.data = (data_q << {hdr_bytes, 3'b000}) & lit_keep;
	end

	assign copy_cmd_o  = dec_copy;
	assign lit_push_o  = step_en & dec_lit_emit;
	assign copy_push_o = step_en & dec_copy_emit;

	// registered back-pressure from either FIFO
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stop_q <= 1'b0;
		end else begin
			stop_q <= lit_afull_i | copy_afull_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
			left_q  <= '0;
			cont_q  <= 1'b0;
		end else begin
			case (state_q)
				IDLE: state_q <= WAIT_SLICE;
				WAIT_SLICE: begin
					if (slice_valid_i) begin
						state_q <= WALK;
						left_q  <= 5'(SLICE_BYTES) - {2'b00, slice_i.garbage};
						cont_q  <= slice_i.lit_first;
					end
				end
				WALK: begin
					if (!stop_q) begin
						cont_q <= 1'b0;	// continuation only ever at byte 0
						if (none) begin
							state_q <= WAIT_SLICE;	// last token done
							left_q  <= '0;
						end else begin
							left_q <= left_q - {1'b0, next_dist};
						end
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// slice payload loaded on accept and shifted on each step
	always_ff @(posedge clk) begin
		if (ready_o && slice_valid_i) begin
			data_q <= slice_i.data;
			mask_q <= slice_i.tok_pos;
			addr_q <= slice_i.addr;
		end else if (step_en) begin
			data_q <= data_q << {next_dist, 3'b000};
			mask_q <= mask_q << next_dist;
			addr_q <= addr_q + addr_step;
		end
	end

	// every further token start lies before the slice end so left_q never wraps
	a_next_in_slice: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == WALK && !none) |-> ({1'b0, next_dist} < left_q))
		else $error("token start beyond the slice end");

endmodule

/* parser/token_decode.sv */
// combinational decode of the head token: literal and copy fields, clipped count, address step
module token_decode import snappy_pkg::*; (
	input  byte_t [3:0] head_i,		// head_i[3] is the tag byte
	input  logic        cont_i,
	input  logic [4:0]  left_i,
	input  addr_t       addr_i,
	input  logic [3:0]  next_dist_i,
	input  logic        none_i,
	output lit_cmd_t    lit_cmd_o,
	output logic        lit_emit_o,
	output copy_cmd_t   copy_cmd_o,
	output logic        copy_emit_o,
	output addr_t       addr_step_o,
	output logic [1:0]  hdr_bytes_o
);

	byte_t      b0, b1, b2;
	logic [5:0] code;		// upper six bits of the tag byte
	logic [16:0] lit_len;	// 1..65536
	logic [4:0] avail;		// content bytes behind the header
	logic [4:0] span;		// continuation run length
	logic [4:0] lit_cnt;
	logic [4:0] cnt_m1;
	copy_len_t  copy_len;

	always_comb begin
		b0          = head_i[3];
		b1          = head_i[2];
		b2          = head_i[1];
		code        = b0[7:2];
		lit_len     = {11'd0, code} + 17'd1;
		hdr_bytes_o = 2'd1;
		span        = none_i ? left_i : {1'b0, next_dist_i};
		avail       = '0;
		lit_cnt     = '0;
		copy_len    = '0;
		lit_emit_o  = 1'b0;
		copy_emit_o = 1'b0;
		addr_step_o = '0;
		copy_cmd_o  = '{addr: addr_i, offset: '0, len: '0};
		if (cont_i) begin	// content up to the next start or slice end
			hdr_bytes_o = 2'd0;
			lit_cnt     = span;
			addr_step_o = {11'd0, span};
		end else begin
			case (b0[1:0])
				TAG_LIT: begin
					if (code == LIT_LEN_1B) begin
						hdr_bytes_o = 2'd2;
						lit_len     = {9'd0, b1} + 17'd1;
					end else if (code == LIT_LEN_2B) begin
						hdr_bytes_o = 2'd3;
						lit_len     = {1'b0, b2, b1} + 17'd1;	// little endian
					end
					avail       = left_i - {3'b000, hdr_bytes_o};
					lit_cnt     = (lit_len < {12'd0, avail}) ? lit_len[4:0] : avail;
					addr_step_o = lit_len[15:0];	// full length, even past the slice
				end
				TAG_COPY2: begin
					hdr_bytes_o       = 2'd2;
					copy_len          = {4'd0, b0[4:2]} + 7'd4;
					copy_cmd_o.offset = {5'd0, b0[7:5], b1};
					copy_emit_o       = 1'b1;
				end
				TAG_COPY3: begin
					hdr_bytes_o       = 2'd3;
					copy_len          = {1'b0, code} + 7'd1;
					copy_cmd_o.offset = {b2, b1};
					copy_emit_o       = 1'b1;
				end
				default: ;	// tag 11 never sent
			endcase
			if (copy_emit_o) begin
				addr_step_o = {9'd0, copy_len};
			end
		end
		copy_cmd_o.len = copy_len;
		lit_emit_o     = (lit_cnt != 5'd0);	// header at slice end yields nothing
		cnt_m1         = lit_cnt - 5'd1;
		lit_cmd_o      = '{addr: addr_i, cnt_m1: cnt_m1[3:0], data: '0};	// walker fills data
	end

	// the slice source keeps to supported tags and whole headers
	always_comb begin
		if (!cont_i && left_i != 5'd0) begin
			a_tag_ok: assert final (b0[1:0] != 2'b11)
				else $error("unsupported tag 11");
			a_lit_code_ok: assert final (b0[1:0] != TAG_LIT || code <= LIT_LEN_2B)
				else $error("unsupported literal length code %0d", code);
			a_hdr_inside: assert final ({3'b000, hdr_bytes_o} <= left_i)
				else $error("token header crosses slice end");
		end
	end

endmodule

/* verilog/cmd_fifo.sv */
// synchronous command FIFO with almost-full, output register and prefetch
module cmd_fifo #(
	parameter int  FIFO_DEPTH  = 16,
	parameter int  AFULL_LEVEL = FIFO_DEPTH - 3,
	parameter type entry_t     = logic [7:0]
) (
	input  logic   clk,
	input  logic   rst_n,
	input  entry_t din_i,
	input  logic   push_i,
	output logic   afull_o,
	output logic   empty_o,	// RAM and output stage both empty
	output entry_t dout_o,
	output logic   valid_o,
	input  logic   rd_i		// one pulse per consumed entry
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = PTR_W + 1;

	entry_t           mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
	logic [CNT_W-1:0] count_q;	// entries in RAM, output stage excluded
	entry_t           dout_q;
	logic             valid_q;
	logic             ram_rd;

	// refill the output stage when it is free or being consumed
	assign ram_rd  = (count_q != '0) && (!valid_q || rd_i);
	assign afull_o = count_q >= CNT_W'(AFULL_LEVEL);
	assign empty_o = (count_q == '0) && !valid_q;
	assign dout_o  = dout_q;
	assign valid_o = valid_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			valid_q  <= 1'b0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (ram_rd) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({push_i, ram_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;	// none or both
			endcase
			if (ram_rd) begin
				valid_q <= 1'b1;
			end else if (rd_i) begin
				valid_q <= 1'b0;	// drained
			end
		end
	end

	// storage and output stage
	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr_q] <= din_i;
		end
		if (ram_rd) begin
			dout_q <= mem[rd_ptr_q];
		end
	end

	// almost-full must leave room for the pushes behind the walker's stop flag
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push_i |-> count_q != CNT_W'(FIFO_DEPTH))
		else $error("push into full command FIFO");
	a_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
		rd_i |-> valid_q)
		else $error("read without valid command");

endmodule

/* verilog/lead_zero_count.sv */
// 16-bit leading-zero counter, two levels of 4-bit priority encoders
module lead_zero_count import snappy_pkg::*; (
	input  tok_mask_t  x_i,
	output logic       none_o,	// no bit set
	output logic [3:0] count_o	// zeros above the first set bit
);

	// {found, leading zeros} of one nibble, msb first
	function automatic logic [2:0] penc4(input logic [3:0] v);
		logic [2:0] r;
		if (v[3])      r = 3'b100;
		else if (v[2]) r = 3'b101;
		else if (v[1]) r = 3'b110;
		else if (v[0]) r = 3'b111;
		else           r = 3'b000;
		return r;
	endfunction

	logic [2:0] grp [4];	// grp[0] is the top nibble
	logic [3:0] any;		// per-nibble found bits, top nibble in any[3]
	logic [2:0] sel;

	always_comb begin
		for (int g = 0; g < 4; g++) begin
			grp[g]     = penc4(x_i[15 - 4 * g -: 4]);
			any[3 - g] = grp[g][2];
		end
		sel     = penc4(any);	// first nibble with a set bit
		none_o  = !sel[2];
		count_o = {sel[1:0], grp[sel[1:0]][1:0]};
	end

endmodule

/* common/snappy_pkg.sv */
// shared widths, slice and command structs, walker state enum and token codes
package snappy_pkg;

	localparam int SLICE_BYTES = 16;	// bytes per compressed slice

	// token tag codes, low two bits of the tag byte
	localparam logic [1:0] TAG_LIT   = 2'b00;
	localparam logic [1:0] TAG_COPY2 = 2'b01;	// copy with 1-byte offset extension
	localparam logic [1:0] TAG_COPY3 = 2'b10;	// copy with 2-byte offset

	// literal length codes that pull extra length bytes
	localparam logic [5:0] LIT_LEN_1B = 6'd60;	// one extra length byte
	localparam logic [5:0] LIT_LEN_2B = 6'd61;	// two extra bytes, little endian

	typedef logic [7:0]   byte_t;
	typedef logic [15:0]  addr_t;		// output byte address
	typedef logic [15:0]  offset_t;		// copy back-reference distance
	typedef logic [6:0]   copy_len_t;	// 1..64
	typedef logic [15:0]  tok_mask_t;	// bit 15 marks byte 0
	typedef logic [3:0]   lit_cnt_t;	// byte count minus one
	typedef logic [127:0] slice_data_t;	// byte 0 in bits 127:120

	// one slice as delivered by the first-level parser
	typedef struct packed {
		slice_data_t data;
		tok_mask_t   tok_pos;	// token start positions
		addr_t       addr;		// output address of byte 0
		logic        lit_first;	// byte 0 is literal content of an earlier header
		logic [2:0]  garbage;	// unused bytes at the tail
	} slice_t;

	// literal command, content left aligned
	typedef struct packed {
		addr_t       addr;
		lit_cnt_t    cnt_m1;
		slice_data_t data;	// first content byte on top, zeros below the count
	} lit_cmd_t;

	// copy command, always whole
	typedef struct packed {
		addr_t     addr;
		offset_t   offset;
		copy_len_t len;
	} copy_cmd_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_SLICE,	// ready for the next slice
		WALK		// one token per cycle
	} walk_state_e;

endpackage
